/* hdl/soc_pkg.sv */
package soc_pkg;

	// ============================================================
	// widths with a meaning on the bus
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] window_t;
	typedef logic [2:0] reg_index_t;
	typedef logic [9:0] led_t;

	// ============================================================
	// request toward the target, response back to the master
	typedef struct packed {
		logic request;
		logic rw;
		addr_t address;
		data_t wdata;
	} bus_req_t;

	typedef struct packed {
		logic ready;
		data_t rdata;
	} bus_rsp_t;

	// near windows on address bits 31:28
	localparam window_t WIN_ROM = 4'h0;
	localparam window_t WIN_RAM = 4'h2;
	localparam window_t WIN_BRIDGE = 4'h5;

	// far windows on address bits 27:24
	localparam window_t WIN_TIMER = 4'h5;
	localparam window_t WIN_SYSREG = 4'h9;

	// system register map
	localparam reg_index_t SYSREG_DEVICE_ID = 3'd0;
	localparam reg_index_t SYSREG_FREQUENCY = 3'd1;
	localparam reg_index_t SYSREG_RAM_SIZE = 3'd2;
	localparam reg_index_t SYSREG_LEDS = 3'd3;

	// timer register map
	localparam reg_index_t TIMER_COUNT = 3'd0;
	localparam reg_index_t TIMER_COMPARE = 3'd1;
	localparam reg_index_t TIMER_CONTROL = 3'd2;

	// ============================================================
	typedef enum logic {ARB_IDLE, ARB_BUSY} arb_state_t;
	typedef enum logic [1:0] {BR_IDLE, BR_FAR, BR_DONE} bridge_state_t;

endpackage

/* hdl/soc_bus_arbiter.sv */
`timescale 1ns/1ps

module soc_bus_arbiter (
	input  logic              i_clock,
	input  logic              i_rst,
	input  soc_pkg::bus_req_t i_ibus_req,
	output soc_pkg::bus_rsp_t o_ibus_rsp,
	input  soc_pkg::bus_req_t i_dbus_req,
	output soc_pkg::bus_rsp_t o_dbus_rsp,
	output soc_pkg::bus_req_t o_bus_req,
	input  soc_pkg::bus_rsp_t i_bus_rsp
);
	import soc_pkg::*;

	arb_state_t state;
	logic grant_dbus;
	logic bus_done;
	bus_req_t bus_req;

	assign bus_done = (state == ARB_BUSY) && i_bus_rsp.ready;

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ARB_IDLE;
			grant_dbus <= 1'b0;
			bus_req.request <= 1'b0;
		end else begin
			case (state)
				ARB_IDLE: begin
					// data port has fixed priority
					if (i_dbus_req.request) begin
						bus_req <= i_dbus_req;
						grant_dbus <= 1'b1;
						state <= ARB_BUSY;
					end else if (i_ibus_req.request) begin
						// instruction port is read only
						bus_req.request <= 1'b1;
						bus_req.rw <= 1'b0;
						bus_req.address <= i_ibus_req.address;
						bus_req.wdata <= '0;
						grant_dbus <= 1'b0;
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (i_bus_rsp.ready) begin
						bus_req.request <= 1'b0;
						state <= ARB_IDLE;
					end
				end
				default: begin
					state <= ARB_IDLE;
				end
			endcase
		end
	end

	assign o_bus_req = bus_req;

	// response goes only to the granted port
	assign o_dbus_rsp.ready = bus_done && grant_dbus;
	assign o_dbus_rsp.rdata = i_bus_rsp.rdata;
	assign o_ibus_rsp.ready = bus_done && !grant_dbus;
	assign o_ibus_rsp.rdata = i_bus_rsp.rdata;

endmodule

/* hdl/soc_bus_decoder.sv */
`timescale 1ns/1ps

module soc_bus_decoder (
	input  logic              i_clock,
	input  logic              i_rst,
	input  soc_pkg::bus_req_t i_bus_req,
	output soc_pkg::bus_rsp_t o_bus_rsp,
	output soc_pkg::bus_req_t o_rom_req,
	input  soc_pkg::bus_rsp_t i_rom_rsp,
	output soc_pkg::bus_req_t o_ram_req,
	input  soc_pkg::bus_rsp_t i_ram_rsp,
	output soc_pkg::bus_req_t o_bridge_req,
	input  soc_pkg::bus_rsp_t i_bridge_rsp,
	output logic              o_fault,
	output soc_pkg::addr_t    o_fault_address
);
	import soc_pkg::*;

	window_t window;
	logic rom_sel;
	logic ram_sel;
	logic bridge_sel;
	logic unmapped;
	logic fault_ready;

	assign window = i_bus_req.address[31:28];
	assign rom_sel = window == WIN_ROM;
	assign ram_sel = window == WIN_RAM;
	assign bridge_sel = window == WIN_BRIDGE;
	assign unmapped = i_bus_req.request && !(rom_sel || ram_sel || bridge_sel);

	always_comb begin
		o_rom_req = i_bus_req;
		o_rom_req.request = i_bus_req.request && rom_sel;
		o_ram_req = i_bus_req;
		o_ram_req.request = i_bus_req.request && ram_sel;
		o_bridge_req = i_bus_req;
		o_bridge_req.request = i_bus_req.request && bridge_sel;
	end

	always_comb begin
		if (rom_sel) begin
			o_bus_rsp = i_rom_rsp;
		end else if (ram_sel) begin
			o_bus_rsp = i_ram_rsp;
		end else if (bridge_sel) begin
			o_bus_rsp = i_bridge_rsp;
		end else begin
			o_bus_rsp.ready = fault_ready;
			o_bus_rsp.rdata = '0;
		end
	end

	// ============================================================
	// unmapped window completes after one cycle and leaves a sticky fault
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			fault_ready <= 1'b0;
			o_fault <= 1'b0;
			o_fault_address <= '0;
		end else begin
			fault_ready <= unmapped && !fault_ready;
			if (unmapped && !fault_ready) begin
				o_fault <= 1'b1;
				o_fault_address <= i_bus_req.address;
			end
		end
	end

endmodule

/* hdl/soc_brom.sv */
`timescale 1ns/1ps

module soc_brom #(
	parameter int unsigned ROM_WORDS = 16
) (
	input  logic              i_clock,
	input  logic              i_rst,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);
	import soc_pkg::*;

	localparam int unsigned INDEX_W = (ROM_WORDS > 1) ? $clog2(ROM_WORDS) : 1;

	data_t rom [0:ROM_WORDS-1];
	logic [INDEX_W-1:0] index;
	logic ready;
	data_t rdata;

	initial $readmemh("rom.hex", rom);

	// word index wraps at the rom size
	assign index = i_req.address[INDEX_W+1:2];

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready <= 1'b0;
		end else begin
			ready <= i_req.request && !ready;
		end
	end

	// writes get a ready and change nothing
	always_ff @(posedge i_clock) begin
		if (i_req.request && !ready) begin
			rdata <= rom[index];
		end
	end

	assign o_rsp.ready = ready;
	assign o_rsp.rdata = rdata;

endmodule

/* hdl/soc_ram.sv */
`timescale 1ns/1ps

module soc_ram #(
	parameter int unsigned RAM_WORDS = 256,
	parameter int unsigned RAM_LATENCY = 3
) (
	input  logic              i_clock,
	input  logic              i_rst,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);
	import soc_pkg::*;

	localparam int unsigned INDEX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
	localparam int unsigned COUNT_W = $clog2(RAM_LATENCY + 1);

	data_t mem [0:RAM_WORDS-1];
	logic [INDEX_W-1:0] index;
	logic [COUNT_W-1:0] countdown;
	logic fire;
	logic ready;
	data_t rdata;

	assign index = i_req.address[INDEX_W+1:2];
	assign fire = i_req.request && !ready && (countdown == '0);

	// countdown reloads between requests
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			countdown <= COUNT_W'(RAM_LATENCY - 1);
			ready <= 1'b0;
		end else begin
			ready <= fire;
			if (!i_req.request || ready) begin
				countdown <= COUNT_W'(RAM_LATENCY - 1);
			end else if (countdown != '0) begin
				countdown <= countdown - 1'b1;
			end
		end
	end

	// access happens on the edge that raises ready
	always_ff @(posedge i_clock) begin
		if (fire) begin
			if (i_req.rw) begin
				mem[index] <= i_req.wdata;
			end else begin
				rdata <= mem[index];
			end
		end
	end

	assign o_rsp.ready = ready;
	assign o_rsp.rdata = rdata;

endmodule

/* hdl/soc_bridge.sv */
`timescale 1ns/1ps

module soc_bridge (
	input  logic              i_clock,
	input  logic              i_rst,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp,
	output soc_pkg::bus_req_t o_timer_req,
	input  soc_pkg::bus_rsp_t i_timer_rsp,
	output soc_pkg::bus_req_t o_sysreg_req,
	input  soc_pkg::bus_rsp_t i_sysreg_rsp
);
	import soc_pkg::*;

	bridge_state_t state;
	bus_req_t far_req;
	window_t far_window;
	logic timer_sel;
	logic sysreg_sel;
	logic far_ready;
	data_t far_rdata;
	data_t rdata;

	// far device select on bits 27:24
	assign far_window = far_req.address[27:24];
	assign timer_sel = far_window == WIN_TIMER;
	assign sysreg_sel = far_window == WIN_SYSREG;

	always_comb begin
		o_timer_req = far_req;
		o_timer_req.request = far_req.request && timer_sel;
		o_sysreg_req = far_req;
		o_sysreg_req.request = far_req.request && sysreg_sel;
	end

	always_comb begin
		if (timer_sel) begin
			far_ready = i_timer_rsp.ready;
			far_rdata = i_timer_rsp.rdata;
		end else if (sysreg_sel) begin
			far_ready = i_sysreg_rsp.ready;
			far_rdata = i_sysreg_rsp.rdata;
		end else begin
			// nothing mapped here so finish with zero
			far_ready = far_req.request;
			far_rdata = '0;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= BR_IDLE;
			far_req.request <= 1'b0;
		end else begin
			case (state)
				BR_IDLE: begin
					if (i_req.request) begin
						far_req <= i_req;
						state <= BR_FAR;
					end
				end
				BR_FAR: begin
					if (far_ready) begin
						far_req.request <= 1'b0;
						rdata <= far_rdata;
						state <= BR_DONE;
					end
				end
				default: begin
					state <= BR_IDLE;
				end
			endcase
		end
	end

	assign o_rsp.ready = state == BR_DONE;
	assign o_rsp.rdata = rdata;

endmodule

/* hdl/soc_sysreg.sv */
`timescale 1ns/1ps

module soc_sysreg #(
	parameter int unsigned DEVICE_ID = 1,
	parameter int unsigned CLOCK_FREQUENCY = 100000000,
	parameter int unsigned RAM_WORDS = 256
) (
	input  logic              i_clock,
	input  logic              i_rst,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp,
	output soc_pkg::led_t     o_leds
);
	import soc_pkg::*;

	reg_index_t index;
	logic access;
	logic ready;
	data_t read_value;
	data_t rdata;

	assign index = i_req.address[4:2];
	assign access = i_req.request && !ready;

	always_comb begin
		case (index)
			SYSREG_DEVICE_ID: read_value = data_t'(DEVICE_ID);
			SYSREG_FREQUENCY: read_value = data_t'(CLOCK_FREQUENCY);
			// size in bytes
			SYSREG_RAM_SIZE: read_value = data_t'(RAM_WORDS * 4);
			SYSREG_LEDS: read_value = data_t'(o_leds);
			default: read_value = '0;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			ready <= 1'b0;
			o_leds <= '0;
		end else begin
			ready <= access;
			if (access && i_req.rw && index == SYSREG_LEDS) begin
				o_leds <= i_req.wdata[$bits(led_t)-1:0];
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			rdata <= read_value;
		end
	end

	assign o_rsp.ready = ready;
	assign o_rsp.rdata = rdata;

endmodule

/* hdl/soc_timer.sv */
`timescale 1ns/1ps

module soc_timer (
	input  logic              i_clock,
	input  logic              i_rst,
	input  soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp,
	output logic              o_timer_irq
);
	import soc_pkg::*;

	reg_index_t index;
	logic access;
	logic ready;
	logic irq_enable;
	data_t count;
	data_t compare;
	data_t read_value;
	data_t rdata;

	assign index = i_req.address[4:2];
	assign access = i_req.request && !ready;

	always_comb begin
		case (index)
			TIMER_COUNT: read_value = count;
			TIMER_COMPARE: read_value = compare;
			TIMER_CONTROL: read_value = {31'b0, irq_enable};
			default: read_value = '0;
		endcase
	end

	// count runs freely and ignores writes
	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			count <= '0;
			compare <= '1;
			irq_enable <= 1'b0;
			ready <= 1'b0;
		end else begin
			count <= count + 1'b1;
			ready <= access;
			if (access && i_req.rw) begin
				case (index)
					TIMER_COMPARE: compare <= i_req.wdata;
					TIMER_CONTROL: irq_enable <= i_req.wdata[0];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			rdata <= read_value;
		end
	end

	assign o_timer_irq = irq_enable && (count >= compare);
	assign o_rsp.ready = ready;
	assign o_rsp.rdata = rdata;

endmodule

/* hdl/soc_top.sv */
`timescale 1ns/1ps

module soc_top #(
	parameter int unsigned RAM_WORDS = 256,
	parameter int unsigned RAM_LATENCY = 3,
	parameter int unsigned ROM_WORDS = 16,
	parameter int unsigned DEVICE_ID = 1,
	parameter int unsigned CLOCK_FREQUENCY = 100000000
) (
	input  logic              i_clock,
	input  logic              i_rst,
	input  soc_pkg::bus_req_t i_ibus_req,
	output soc_pkg::bus_rsp_t o_ibus_rsp,
	input  soc_pkg::bus_req_t i_dbus_req,
	output soc_pkg::bus_rsp_t o_dbus_rsp,
	output soc_pkg::led_t     o_leds,
	output logic              o_timer_irq,
	output logic              o_fault,
	output soc_pkg::addr_t    o_fault_address
);
	import soc_pkg::*;

	bus_req_t near_req;
	bus_rsp_t near_rsp;
	bus_req_t rom_req;
	bus_rsp_t rom_rsp;
	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t bridge_req;
	bus_rsp_t bridge_rsp;
	bus_req_t timer_req;
	bus_rsp_t timer_rsp;
	bus_req_t sysreg_req;
	bus_rsp_t sysreg_rsp;

	// ============================================================
	// near bus
	soc_bus_arbiter arbiter (
		.i_clock    (i_clock),
		.i_rst      (i_rst),
		.i_ibus_req (i_ibus_req),
		.o_ibus_rsp (o_ibus_rsp),
		.i_dbus_req (i_dbus_req),
		.o_dbus_rsp (o_dbus_rsp),
		.o_bus_req  (near_req),
		.i_bus_rsp  (near_rsp)
	);

	soc_bus_decoder decoder (
		.i_clock         (i_clock),
		.i_rst           (i_rst),
		.i_bus_req       (near_req),
		.o_bus_rsp       (near_rsp),
		.o_rom_req       (rom_req),
		.i_rom_rsp       (rom_rsp),
		.o_ram_req       (ram_req),
		.i_ram_rsp       (ram_rsp),
		.o_bridge_req    (bridge_req),
		.i_bridge_rsp    (bridge_rsp),
		.o_fault         (o_fault),
		.o_fault_address (o_fault_address)
	);

	soc_brom #(.ROM_WORDS(ROM_WORDS)) rom (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_req   (rom_req),
		.o_rsp   (rom_rsp)
	);

	soc_ram #(.RAM_WORDS(RAM_WORDS), .RAM_LATENCY(RAM_LATENCY)) ram (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_req   (ram_req),
		.o_rsp   (ram_rsp)
	);

	// ============================================================
	// far bus behind the bridge
	soc_bridge bridge (
		.i_clock      (i_clock),
		.i_rst        (i_rst),
		.i_req        (bridge_req),
		.o_rsp        (bridge_rsp),
		.o_timer_req  (timer_req),
		.i_timer_rsp  (timer_rsp),
		.o_sysreg_req (sysreg_req),
		.i_sysreg_rsp (sysreg_rsp)
	);

	soc_sysreg #(
		.DEVICE_ID       (DEVICE_ID),
		.CLOCK_FREQUENCY (CLOCK_FREQUENCY),
		.RAM_WORDS       (RAM_WORDS)
	) sysreg (
		.i_clock (i_clock),
		.i_rst   (i_rst),
		.i_req   (sysreg_req),
		.o_rsp   (sysreg_rsp),
		.o_leds  (o_leds)
	);

	soc_timer timer (
		.i_clock     (i_clock),
		.i_rst       (i_rst),
		.i_req       (timer_req),
		.o_rsp       (timer_rsp),
		.o_timer_irq (o_timer_irq)
	);

endmodule

/* tests/tb_soc.sv */
`timescale 1ns/1ps

module tb_soc;
	import soc_pkg::*;

	localparam int unsigned RAM_WORDS = 256;
	localparam int unsigned RAM_LATENCY = 3;
	localparam int unsigned ROM_WORDS = 16;
	localparam int unsigned DEVICE_ID = 1;
	localparam int unsigned CLOCK_FREQUENCY = 100000000;
	localparam int ROM_INDEX_W = $clog2(ROM_WORDS);
	localparam int RAM_INDEX_W = $clog2(RAM_WORDS);

	// transactions per test
	localparam int ROM_READS = 32;
	localparam int RAM_ACCESSES = 96;
	localparam int IBUS_READS = 32;
	localparam int DUAL_ROUNDS = 24;
	localparam int FAULT_ACCESSES = 8;
	// fill, rom write check and the register accesses on top
	localparam int TXN_COUNT = ROM_READS + 2 + RAM_WORDS + RAM_ACCESSES + IBUS_READS
		+ 2 * DUAL_ROUNDS + 12 + FAULT_ACCESSES;
	localparam int WATCHDOG_CYCLES = TXN_COUNT * 20 + 8;

	logic clock;
	logic rst;
	bus_req_t ibus_req;
	bus_rsp_t ibus_rsp;
	bus_req_t dbus_req;
	bus_rsp_t dbus_rsp;
	led_t leds;
	logic timer_irq;
	logic fault;
	addr_t fault_address;

	data_t rom_model [0:ROM_WORDS-1];
	data_t ram_model [0:RAM_WORDS-1];
	int error_count;
	int check_count;
	int errors_at_start;
	int checks_at_start;

	soc_top #(
		.RAM_WORDS       (RAM_WORDS),
		.RAM_LATENCY     (RAM_LATENCY),
		.ROM_WORDS       (ROM_WORDS),
		.DEVICE_ID       (DEVICE_ID),
		.CLOCK_FREQUENCY (CLOCK_FREQUENCY)
	) UUT (
		.i_clock         (clock),
		.i_rst           (rst),
		.i_ibus_req      (ibus_req),
		.o_ibus_rsp      (ibus_rsp),
		.i_dbus_req      (dbus_req),
		.o_dbus_rsp      (dbus_rsp),
		.o_leds          (leds),
		.o_timer_irq     (timer_irq),
		.o_fault         (fault),
		.o_fault_address (fault_address)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// ============================================================
	// helpers
	task automatic report_mismatch(input string what, input data_t got, input data_t expected);
		error_count++;
		$display("MISMATCH at %0t ns: %s read %h, expected %h", $time, what, got, expected);
	endtask

	task automatic finish_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, check_count - checks_at_start,
			error_count - errors_at_start);
		checks_at_start = check_count;
		errors_at_start = error_count;
	endtask

	function automatic logic [ROM_INDEX_W-1:0] rom_index(input addr_t address);
		return address[ROM_INDEX_W+1:2];
	endfunction

	function automatic logic [RAM_INDEX_W-1:0] ram_index(input addr_t address);
		return address[RAM_INDEX_W+1:2];
	endfunction

	// expected read data for the rom and ram windows
	function automatic data_t model_read(input addr_t address);
		if (address[31:28] == WIN_ROM) begin
			return rom_model[rom_index(address)];
		end else begin
			return ram_model[ram_index(address)];
		end
	endfunction

	function automatic addr_t random_address(input window_t window);
		addr_t address;
		address = $urandom;
		address[31:28] = window;
		address[1:0] = 2'b00;
		return address;
	endfunction

	function automatic addr_t far_address(input window_t far_window, input reg_index_t index);
		addr_t address;
		address = '0;
		address[31:28] = WIN_BRIDGE;
		address[27:24] = far_window;
		address[4:2] = index;
		return address;
	endfunction

	// one full handshake on either port up to the negedge that sees ready
	task automatic run_transaction(input logic use_dbus, input logic write, input addr_t address,
		input data_t wdata, output data_t rdata);
		bus_req_t req;
		bus_rsp_t rsp;
		logic done;
		logic other_ready;
		req.request = 1'b1;
		req.rw = write;
		req.address = address;
		req.wdata = wdata;
		done = 1'b0;
		@(negedge clock);
		if (use_dbus) begin
			dbus_req = req;
		end else begin
			ibus_req = req;
		end
		while (!done) begin
			@(negedge clock);
			rsp = use_dbus ? dbus_rsp : ibus_rsp;
			if (rsp.ready) begin
				done = 1'b1;
				rdata = rsp.rdata;
				if (use_dbus) begin
					dbus_req.request = 1'b0;
				end else begin
					ibus_req.request = 1'b0;
				end
				// the near bus serves one port per cycle
				other_ready = use_dbus ? ibus_rsp.ready : dbus_rsp.ready;
				check_count++;
				if (other_ready !== 1'b0) begin
					report_mismatch("ready on the other port", {31'b0, other_ready}, 32'd0);
				end
			end
		end
	endtask

	// ============================================================
	// tests
	task automatic read_rom_words();
		addr_t address;
		data_t rdata;
		data_t wdata;
		for (int i = 0; i < ROM_READS; i++) begin
			address = random_address(WIN_ROM);
			run_transaction(i % 2 == 1, 1'b0, address, '0, rdata);
			check_count++;
			if (rdata !== model_read(address)) begin
				report_mismatch("rom", rdata, model_read(address));
			end
		end
		// a write is acknowledged and leaves the rom unchanged
		address = random_address(WIN_ROM);
		wdata = $urandom;
		run_transaction(1'b1, 1'b1, address, wdata, rdata);
		run_transaction(1'b1, 1'b0, address, '0, rdata);
		check_count++;
		if (rdata !== model_read(address)) begin
			report_mismatch("rom after write", rdata, model_read(address));
		end
		finish_test("rom");
	endtask

	task automatic exercise_ram();
		addr_t address;
		data_t rdata;
		data_t wdata;
		logic [31:0] pick;
		for (int i = 0; i < RAM_WORDS; i++) begin
			address = addr_t'(i) << 2;
			address[31:28] = WIN_RAM;
			wdata = $urandom;
			run_transaction(1'b1, 1'b1, address, wdata, rdata);
			ram_model[ram_index(address)] = wdata;
		end
		for (int i = 0; i < RAM_ACCESSES; i++) begin
			address = random_address(WIN_RAM);
			pick = $urandom;
			if (pick[0]) begin
				wdata = $urandom;
				run_transaction(1'b1, 1'b1, address, wdata, rdata);
				ram_model[ram_index(address)] = wdata;
			end else begin
				run_transaction(1'b1, 1'b0, address, '0, rdata);
				check_count++;
				if (rdata !== model_read(address)) begin
					report_mismatch("ram data port", rdata, model_read(address));
				end
			end
		end
		for (int i = 0; i < IBUS_READS; i++) begin
			address = random_address(WIN_RAM);
			pick = $urandom;
			wdata = $urandom;
			// instruction port ignores rw and wdata
			run_transaction(1'b0, pick[0], address, wdata, rdata);
			check_count++;
			if (rdata !== model_read(address)) begin
				report_mismatch("ram instruction port", rdata, model_read(address));
			end
		end
		finish_test("ram");
	endtask

	task automatic race_both_ports();
		addr_t iaddr;
		addr_t daddr;
		data_t irdata;
		data_t drdata;
		logic [31:0] pick;
		for (int i = 0; i < DUAL_ROUNDS; i++) begin
			pick = $urandom;
			iaddr = random_address(pick[0] ? WIN_RAM : WIN_ROM);
			daddr = random_address(pick[1] ? WIN_RAM : WIN_ROM);
			fork
				run_transaction(1'b0, 1'b0, iaddr, '0, irdata);
				run_transaction(1'b1, 1'b0, daddr, '0, drdata);
			join
			check_count += 2;
			if (irdata !== model_read(iaddr)) begin
				report_mismatch("shared instruction port", irdata, model_read(iaddr));
			end
			if (drdata !== model_read(daddr)) begin
				report_mismatch("shared data port", drdata, model_read(daddr));
			end
		end
		finish_test("dual");
	endtask

	task automatic probe_sysregs();
		data_t rdata;
		data_t wdata;
		run_transaction(1'b1, 1'b0, far_address(WIN_SYSREG, SYSREG_DEVICE_ID), '0, rdata);
		check_count++;
		if (rdata !== 32'd1) begin
			report_mismatch("device id", rdata, 32'd1);
		end
		run_transaction(1'b1, 1'b0, far_address(WIN_SYSREG, SYSREG_FREQUENCY), '0, rdata);
		check_count++;
		if (rdata !== 32'd100000000) begin
			report_mismatch("clock frequency", rdata, 32'd100000000);
		end
		run_transaction(1'b1, 1'b0, far_address(WIN_SYSREG, SYSREG_RAM_SIZE), '0, rdata);
		check_count++;
		if (rdata !== 32'd1024) begin
			report_mismatch("ram size", rdata, 32'd1024);
		end
		// only the low 10 bits are kept
		wdata = $urandom;
		run_transaction(1'b1, 1'b1, far_address(WIN_SYSREG, SYSREG_LEDS), wdata, rdata);
		run_transaction(1'b1, 1'b0, far_address(WIN_SYSREG, SYSREG_LEDS), '0, rdata);
		check_count += 2;
		if (rdata !== {22'b0, wdata[9:0]}) begin
			report_mismatch("led register", rdata, {22'b0, wdata[9:0]});
		end
		if (leds !== wdata[9:0]) begin
			report_mismatch("led pins", {22'b0, leds}, {22'b0, wdata[9:0]});
		end
		finish_test("sysreg");
	endtask

	task automatic step_timer_interrupt();
		data_t first;
		data_t second;
		data_t rdata;
		run_transaction(1'b1, 1'b0, far_address(WIN_TIMER, TIMER_COUNT), '0, first);
		run_transaction(1'b1, 1'b0, far_address(WIN_TIMER, TIMER_COUNT), '0, second);
		check_count += 2;
		if (second <= first) begin
			error_count++;
			$display("timer count did not advance at %0t ns: %h then %h", $time, first, second);
		end
		if (timer_irq !== 1'b0) begin
			report_mismatch("irq before enable", {31'b0, timer_irq}, 32'd0);
		end
		// compare already behind the running count
		run_transaction(1'b1, 1'b1, far_address(WIN_TIMER, TIMER_COMPARE), second, rdata);
		run_transaction(1'b1, 1'b1, far_address(WIN_TIMER, TIMER_CONTROL), 32'd1, rdata);
		check_count++;
		if (timer_irq !== 1'b1) begin
			report_mismatch("irq after enable", {31'b0, timer_irq}, 32'd1);
		end
		run_transaction(1'b1, 1'b1, far_address(WIN_TIMER, TIMER_CONTROL), 32'd0, rdata);
		check_count++;
		if (timer_irq !== 1'b0) begin
			report_mismatch("irq after disable", {31'b0, timer_irq}, 32'd0);
		end
		finish_test("timer");
	endtask

	task automatic provoke_faults();
		addr_t address;
		data_t rdata;
		window_t window;
		logic [31:0] pick;
		// unmapped far window reads zero and raises no fault
		window = WIN_TIMER;
		while (window == WIN_TIMER || window == WIN_SYSREG) begin
			pick = $urandom;
			window = pick[3:0];
		end
		address = far_address(window, pick[6:4]);
		run_transaction(1'b1, 1'b0, address, '0, rdata);
		check_count += 2;
		if (rdata !== 32'd0) begin
			report_mismatch("unmapped far", rdata, 32'd0);
		end
		if (fault !== 1'b0) begin
			report_mismatch("fault after far access", {31'b0, fault}, 32'd0);
		end
		for (int i = 0; i < FAULT_ACCESSES; i++) begin
			window = WIN_ROM;
			while (window == WIN_ROM || window == WIN_RAM || window == WIN_BRIDGE) begin
				pick = $urandom;
				window = pick[3:0];
			end
			address = random_address(window);
			run_transaction(pick[4], pick[4] && pick[5], address, $urandom, rdata);
			check_count += 3;
			if (rdata !== 32'd0) begin
				report_mismatch("unmapped near", rdata, 32'd0);
			end
			if (fault !== 1'b1) begin
				report_mismatch("fault flag", {31'b0, fault}, 32'd1);
			end
			if (fault_address !== address) begin
				report_mismatch("fault address", fault_address, address);
			end
		end
		finish_test("fault");
	endtask

	// ============================================================
	initial begin
		void'($urandom(29));
		rst = 1'b1;
		ibus_req = '0;
		dbus_req = '0;
		error_count = 0;
		check_count = 0;
		errors_at_start = 0;
		checks_at_start = 0;
		$readmemh("rom.hex", rom_model);
		repeat (4) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		check_count += 5;
		if (ibus_rsp.ready !== 1'b0 || dbus_rsp.ready !== 1'b0) begin
			report_mismatch("ready after reset", {30'b0, ibus_rsp.ready, dbus_rsp.ready}, 32'd0);
		end
		if (fault !== 1'b0 || timer_irq !== 1'b0) begin
			report_mismatch("fault and irq after reset", {30'b0, fault, timer_irq}, 32'd0);
		end
		if (leds !== '0) begin
			report_mismatch("leds after reset", {22'b0, leds}, 32'd0);
		end
		finish_test("reset");
		read_rom_words();
		exercise_ram();
		race_both_ports();
		probe_sysregs();
		step_timer_interrupt();
		provoke_faults();
		$display("total: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("timeout: bus transactions still pending after %0d cycles", WATCHDOG_CYCLES);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* rom.hex */
// one 32-bit data word per line in hex
// lines are word indices 0 to 15 of the rom
13579bdf
2468ace0
deadbeef
0badf00d
00000001
80000000
a5a5a5a5
5a5a5a5a
12345678
87654321
fedcba98
0f0f0f0f
f0f0f0f0
c001d00d
7fffffff
00c0ffee

/* files.f */
hdl/soc_pkg.sv
hdl/soc_bus_arbiter.sv
hdl/soc_bus_decoder.sv
hdl/soc_brom.sv
hdl/soc_ram.sv
hdl/soc_bridge.sv
hdl/soc_sysreg.sv
hdl/soc_timer.sv
hdl/soc_top.sv
tests/tb_soc.sv

/* run.sh */
#!/bin/bash
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f files.f --top-module tb_soc -o tb_soc_sim \
	&& ./obj_dir/tb_soc_sim 2>&1 | tee sim.log \
	|| { echo "build or simulation run failed"; exit 1; }
grep -q "ERRORS FOUND" sim.log \
	&& { echo "simulation reported errors"; exit 1; } \
	|| echo "simulation passed"
exit 0
